/* dv/tb_clock_gen.sv */
// ------------------------------------------------------------------------
// testbench clock and reset source, reset held low for a set number
// of rising clock edges after time zero
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1; // release on a rising edge
    end

endmodule

/* dv/tb_hub75_top.sv */
// ------------------------------------------------------------------------
// directed tests for the HUB75 driver over APB, a panel monitor that
// records every shifted row, latch and display time, and a watchdog
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "hub75_defs.svh"

module tb_hub75_top;
    import hub75_pkg::*;

    typedef logic [`HUB75_APB_AW-1:0] apb_addr_t;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int WIDTH         = `HUB75_WIDTH;
    localparam int HALF          = `HUB75_HALF_HEIGHT;
    localparam int PLANES        = `HUB75_PLANES;
    // upper bound per plane with 8 cycles per column plus the latch
    localparam int PLANE_CYCLES  = WIDTH * 8 + 2;
    localparam int FRAME_CYCLES  = HALF * (PLANES * PLANE_CYCLES
                                   + `HUB75_OE_BASE * ((1 << PLANES) - 1));
    localparam int APB_CYCLES    = 5 * (2 * NUM_PIXELS + 40); // all transfers
    localparam int WATCHDOG_CYCLES = 2 * 2 * FRAME_CYCLES + APB_CYCLES + RESET_CYCLES;

    logic        clk, arst_n;
    logic        psel, penable, pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    hub75_t      panel;

    pixel_t      shadow [NUM_PIXELS]; // what the host wrote
    ctrl_t       shadow_ctrl;
    logic [31:0] lfsr = 32'h9a145d90;
    string       test_name;

    // monitor state
    rgb_t   cur_top [WIDTH];
    rgb_t   cur_bot [WIDTH];
    rgb_t   seen_top [HALF][PLANES][WIDTH];
    rgb_t   seen_bot [HALF][PLANES][WIDTH];
    int     seen_row [HALF][PLANES];
    int     seen_oe [HALF][PLANES];
    int     col_idx, lat_cnt, oe_len, planes_done, row_changes;
    int     shown_row, shown_plane;
    hub75_t prev_panel;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .clk, .arst_n
    );

    hub75_top dut (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .panel
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
        if (exp !== act)
            stop_with_failure($sformatf("error %s %s expected %h actual %h",
                                        test_name, what, exp, act));
    endtask

    task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
        if (exp !== act)
            stop_with_failure($sformatf("error %s %s expected %b actual %b",
                                        test_name, what, exp, act));
    endtask

    task automatic check_ctrl(input string what, input ctrl_t exp, input ctrl_t act);
        if (exp !== act)
            stop_with_failure($sformatf("error %s %s expected %h actual %h",
                                        test_name, what, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
            stop_with_failure($sformatf("error %s %s expected %b actual %b",
                                        test_name, what, exp, act));
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act)
            stop_with_failure($sformatf("error %s %s expected %0d actual %0d",
                                        test_name, what, exp, act));
    endtask

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic apb_addr_t pixel_addr(input int n);
        return apb_addr_t'(`HUB75_PIX_BASE + 4 * n);
    endfunction

    // a disabled plane shows nothing, a disabled channel stays dark
    function automatic rgb_t expected_bits(input pixel_t px, input int p, input ctrl_t c);
        rgb_t o;
        o = '0;
        if (c.plane_enable[p]) begin
            o.red   = c.rgb_enable[2] ? px.red[p] : 1'b0;
            o.green = c.rgb_enable[1] ? px.green[p] : 1'b0;
            o.blue  = c.rgb_enable[0] ? px.blue[p] : 1'b0;
        end
        return o;
    endfunction

    task automatic apb_transfer(input apb_addr_t addr, input logic wr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err,
                                output int waits);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        waits = 0;
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        int          waits;
        apb_transfer(addr, 1'b1, data, unused, err, waits);
        check_count("write wait states", 0, waits);
    endtask

    // pixel reads inside the panel take one wait state
    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
        int waits;
        int exp_waits;
        exp_waits = (addr >= `HUB75_PIX_BASE && addr < pixel_addr(NUM_PIXELS)) ? 1 : 0;
        apb_transfer(addr, 1'b0, 32'h0, data, err, waits);
        check_count("read wait states", exp_waits, waits);
    endtask

    task automatic write_ctrl(input ctrl_t value);
        logic [31:0] rd;
        logic        err;
        apb_write(`HUB75_CTRL_ADDR, 32'(value), err);
        check_bit("control write slverr", 1'b0, err);
        shadow_ctrl = value;
        apb_read(`HUB75_CTRL_ADDR, rd, err);
        check_bit("control read slverr", 1'b0, err);
        check_ctrl("control readback", value, ctrl_t'(rd[$bits(ctrl_t)-1:0]));
    endtask

    task automatic expect_pixel(input int n);
        logic [31:0] rd;
        logic        err;
        apb_read(pixel_addr(n), rd, err);
        check_bit("pixel read slverr", 1'b0, err);
        check_pixel("pixel readback", shadow[n], pixel_t'(rd[$bits(pixel_t)-1:0]));
    endtask

    // skip the plane in progress, then record one whole frame
    task automatic capture_frame();
        int start;
        start = planes_done;
        while (planes_done < start + 1 + PLANES * HALF) @(negedge clk);
    endtask

    task automatic compare_frame();
        for (int r = 0; r < HALF; r++) begin
            for (int p = 0; p < PLANES; p++) begin
                for (int c = 0; c < WIDTH; c++) begin
                    check_rgb("top colour bits",
                              expected_bits(shadow[r * WIDTH + c], p, shadow_ctrl),
                              seen_top[r][p][c]);
                    check_rgb("bottom colour bits",
                              expected_bits(shadow[(r + HALF) * WIDTH + c], p, shadow_ctrl),
                              seen_bot[r][p][c]);
                end
            end
        end
    endtask

    task automatic reset_values();
        logic [31:0] rd;
        logic        err;
        test_name = "reset_values";
        @(negedge clk); // still in reset
        check_bit("oe_n in reset", 1'b1, panel.oe_n);
        check_bit("latch in reset", 1'b0, panel.latch);
        check_bit("clk_pixel in reset", 1'b0, panel.clk_pixel);
        while (!arst_n) @(negedge clk);
        check_bit("oe_n after reset", 1'b1, panel.oe_n);
        check_bit("latch after reset", 1'b0, panel.latch);
        check_bit("clk_pixel after reset", 1'b0, panel.clk_pixel);
        apb_read(`HUB75_CTRL_ADDR, rd, err);
        check_bit("control read slverr", 1'b0, err);
        check_ctrl("control reset value", '1, ctrl_t'(rd[$bits(ctrl_t)-1:0]));
    endtask

    task automatic register_access();
        logic [31:0] rd;
        logic        err;
        test_name = "register_access";
        rd = rand_bits($bits(ctrl_t));
        write_ctrl(ctrl_t'(rd[$bits(ctrl_t)-1:0]));
        write_ctrl('1);
        for (int i = 0; i < NUM_PIXELS; i++) begin
            rd        = rand_bits($bits(pixel_t));
            shadow[i] = pixel_t'(rd[$bits(pixel_t)-1:0]);
            apb_write(pixel_addr(i), 32'(shadow[i]), err);
            check_bit("pixel write slverr", 1'b0, err);
        end
        for (int i = 0; i < NUM_PIXELS; i++) expect_pixel(i);
        // one past the last pixel, then a hole in the map
        apb_write(pixel_addr(NUM_PIXELS), 32'(~shadow[0]), err);
        check_bit("slverr on write past the panel", 1'b1, err);
        apb_write(apb_addr_t'('h004), 32'h0, err);
        check_bit("slverr on unmapped write", 1'b1, err);
        apb_read(pixel_addr(NUM_PIXELS), rd, err);
        check_bit("slverr on read past the panel", 1'b1, err);
        check_count("data of failed read", 0, int'(rd));
        apb_read(apb_addr_t'('h004), rd, err);
        check_bit("slverr on unmapped read", 1'b1, err);
        check_count("data of failed read", 0, int'(rd));
        expect_pixel(0);
        expect_pixel(NUM_PIXELS - 1);
        apb_read(`HUB75_CTRL_ADDR, rd, err);
        check_ctrl("control after bad writes", shadow_ctrl, ctrl_t'(rd[$bits(ctrl_t)-1:0]));
    endtask

    task automatic frame_content();
        test_name = "frame_content";
        capture_frame();
        compare_frame();
    endtask

    // uses the frame recorded by frame_content
    task automatic plane_weighting();
        test_name = "plane_weighting";
        for (int r = 0; r < HALF; r++) begin
            for (int p = 0; p < PLANES; p++) begin
                check_count("oe_n low cycles", `HUB75_OE_BASE << p, seen_oe[r][p]);
                check_count("latched row", r, seen_row[r][p]);
            end
        end
        check_count("row changes while shown", 0, row_changes);
    endtask

    task automatic channel_plane_masking();
        test_name = "channel_plane_masking";
        write_ctrl('{rgb_enable: 3'b101, plane_enable: '1}); // green off
        capture_frame();
        compare_frame();
        write_ctrl('{rgb_enable: 3'b111, plane_enable: 4'b1011}); // plane 2 off
        capture_frame();
        compare_frame();
        write_ctrl('1);
    endtask

    // panel monitor sampled on the falling edge where pins are settled
    always @(negedge clk) begin
        if (!arst_n) begin
            col_idx     = 0;
            lat_cnt     = 0;
            oe_len      = 0;
            planes_done = 0;
            row_changes = 0;
        end else begin
            if (lat_cnt == 0 && !panel.oe_n)
                stop_with_failure("oe_n went low before the first latch");
            if (panel.clk_pixel && !prev_panel.clk_pixel) begin
                if (panel.rgb_top != prev_panel.rgb_top
                    || panel.rgb_bottom != prev_panel.rgb_bottom)
                    stop_with_failure("colour bits changed as clk_pixel rose");
                if (col_idx < WIDTH) begin
                    cur_top[col_idx] = panel.rgb_top;
                    cur_bot[col_idx] = panel.rgb_bottom;
                end
                col_idx++;
            end
            if (panel.latch) begin
                if (prev_panel.latch)
                    stop_with_failure("latch stayed high for more than one cycle");
                if (col_idx != WIDTH)
                    stop_with_failure("latch came after the wrong number of pixel clocks");
                shown_plane = lat_cnt % PLANES;
                shown_row   = (lat_cnt / PLANES) % HALF; // planes run fastest
                seen_row[shown_row][shown_plane] = int'(panel.row);
                for (int c = 0; c < WIDTH; c++) begin
                    seen_top[shown_row][shown_plane][c] = cur_top[c];
                    seen_bot[shown_row][shown_plane][c] = cur_bot[c];
                end
                col_idx = 0;
                oe_len  = 0;
                lat_cnt++;
            end
            if (!panel.oe_n) begin
                oe_len++;
                if (int'(panel.row) != seen_row[shown_row][shown_plane]) row_changes++;
            end
            if (panel.oe_n && !prev_panel.oe_n && lat_cnt > 0) begin
                seen_oe[shown_row][shown_plane] = oe_len;
                planes_done++;
            end
        end
        prev_panel = panel;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        stop_with_failure("watchdog expired before the tests finished");
    end

    initial begin
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        shadow_ctrl = '1;
        reset_values();
        register_access();
        frame_content();
        plane_weighting();
        channel_plane_masking();
        $display("test passed");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_hub75_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build did not succeed"
    exit 1
fi

output=$(./obj_dir/Vtb_hub75_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

/* sim.f */
+incdir+src
src/hub75_pkg.sv
src/fb_apb_regs.sv
src/framebuffer_ram.sv
src/framebuffer_fetch.sv
src/matrix_scan.sv
src/hub75_top.sv
dv/tb_clock_gen.sv
dv/tb_hub75_top.sv

/* src/fb_apb_regs.sv */
// ------------------------------------------------------------------------
// APB3 slave, holds the control register and maps pixel accesses onto
// framebuffer port A, pixel reads take one wait state
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "hub75_defs.svh"

module fb_apb_regs (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`HUB75_APB_AW-1:0]  paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      ram_en,
    output logic                      ram_we,
    output hub75_pkg::fb_addr_t       ram_addr,
    output hub75_pkg::pixel_t         ram_wdata,
    input  hub75_pkg::pixel_t         ram_rdata,
    output hub75_pkg::ctrl_t          ctrl
);
    import hub75_pkg::*;

    logic                     access;
    logic                     ctrl_hit;
    logic                     pix_hit;
    logic [`HUB75_APB_AW-1:0] pix_offs;
    logic                     rd_wait; // second cycle of a pixel read

    assign access   = psel & penable;
    assign ctrl_hit = (paddr == `HUB75_CTRL_ADDR);
    assign pix_offs = paddr - `HUB75_PIX_BASE;
    assign pix_hit  = (paddr >= `HUB75_PIX_BASE) && (pix_offs < 4 * NUM_PIXELS)
                      && (paddr[1:0] == 2'b00);

    // port A, read issued in the first access cycle only
    assign ram_en    = access & pix_hit & (pwrite | ~rd_wait);
    assign ram_we    = access & pix_hit & pwrite;
    assign ram_addr  = pix_offs[ADDR_W+1:2];
    assign ram_wdata = pixel_t'(pwdata[$bits(pixel_t)-1:0]);

    assign pready  = ~(access & pix_hit & ~pwrite & ~rd_wait);
    assign pslverr = access & ~ctrl_hit & ~pix_hit;

    always_comb begin
        prdata = '0; // also what an error returns
        if (ctrl_hit) begin
            prdata = 32'(ctrl);
        end else if (pix_hit) begin
            prdata = 32'(ram_rdata); // valid once rd_wait is set
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= access & pix_hit & ~pwrite & ~rd_wait;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= CTRL_RESET;
        end else if (access && pwrite && ctrl_hit) begin
            ctrl <= ctrl_t'(pwdata[$bits(ctrl_t)-1:0]);
        end
    end

endmodule

/* src/framebuffer_fetch.sv */
// ------------------------------------------------------------------------
// fetches the top and bottom pixel of one column over port B and reduces
// them to the colour bits of the requested plane, answer 3 cycles later
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "hub75_defs.svh"

module framebuffer_fetch (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req,
    input  hub75_pkg::col_req_t  req_info,
    input  hub75_pkg::ctrl_t     ctrl,
    output logic                 ram_en,
    output hub75_pkg::fb_addr_t  ram_addr,
    input  hub75_pkg::pixel_t    ram_rdata,
    output logic                 rsp_valid,
    output hub75_pkg::rgb_t      rgb_top,
    output hub75_pkg::rgb_t      rgb_bottom
);
    import hub75_pkg::*;

    logic               s1_valid; // top read in flight
    col_req_t           s1_info;
    logic               s2_valid; // bottom read in flight
    logic [PLANE_W-1:0] s2_plane;

    function automatic fb_addr_t pix_addr(col_req_t r, logic bottom);
        int unsigned row;
        row = r.row + (bottom ? `HUB75_HALF_HEIGHT : 0);
        return fb_addr_t'(row * `HUB75_WIDTH + r.column);
    endfunction

    // a bit shows only if set, its channel is on and its plane is on
    function automatic rgb_t plane_bits(pixel_t px, logic [PLANE_W-1:0] p, ctrl_t c);
        rgb_t o;
        o.red   = px.red[p]   & c.rgb_enable[2] & c.plane_enable[p];
        o.green = px.green[p] & c.rgb_enable[1] & c.plane_enable[p];
        o.blue  = px.blue[p]  & c.rgb_enable[0] & c.plane_enable[p];
        return o;
    endfunction

    assign ram_en   = req | s1_valid;
    assign ram_addr = req ? pix_addr(req_info, 1'b0) : pix_addr(s1_info, 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= req;
            s2_valid  <= s1_valid;
            rsp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req) s1_info <= req_info;
        if (s1_valid) begin
            s2_plane <= s1_info.plane;
            rgb_top  <= plane_bits(ram_rdata, s1_info.plane, ctrl); // top word back
        end
        if (s2_valid) rgb_bottom <= plane_bits(ram_rdata, s2_plane, ctrl);
    end

endmodule

/* src/framebuffer_ram.sv */
// ------------------------------------------------------------------------
// dual-port framebuffer, port A read/write for the host, port B read
// only for the scan, both with registered read data
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                 clk,
    input  logic                 a_en,
    input  logic                 a_we,
    input  hub75_pkg::fb_addr_t  a_addr,
    input  hub75_pkg::pixel_t    a_wdata,
    output hub75_pkg::pixel_t    a_rdata,
    input  logic                 b_en,
    input  hub75_pkg::fb_addr_t  b_addr,
    output hub75_pkg::pixel_t    b_rdata
);
    import hub75_pkg::*;

    pixel_t mem [NUM_PIXELS]; // top half first, then bottom

    always_ff @(posedge clk) begin
        if (a_en) begin
            if (a_we) begin
                mem[a_addr] <= a_wdata;
            end
            a_rdata <= mem[a_addr]; // old data on a write
        end
    end

    always_ff @(posedge clk) begin
        if (b_en) begin
            b_rdata <= mem[b_addr];
        end
    end

endmodule

/* src/hub75_defs.svh */
// ------------------------------------------------------------------------
// panel geometry, colour depth, display timing and APB address map
// include wherever these sizes are needed
// ------------------------------------------------------------------------
`ifndef HUB75_DEFS_SVH
`define HUB75_DEFS_SVH

// panel geometry, two halves scanned together
`define HUB75_WIDTH        8
`define HUB75_HALF_HEIGHT  4

// bits per colour channel, one brightness plane per bit
`define HUB75_PLANES       4

// clk cycles that plane 0 is shown, plane p gets base << p
`define HUB75_OE_BASE      4

// APB map
`define HUB75_APB_AW       12
`define HUB75_CTRL_ADDR    12'h000
`define HUB75_PIX_BASE     12'h100 // pixel n at base + 4*n

`endif

/* src/hub75_pkg.sv */
// ------------------------------------------------------------------------
// types shared by the panel driver RTL and its testbench
// ------------------------------------------------------------------------
`include "hub75_defs.svh"

package hub75_pkg;

    localparam int COL_W      = $clog2(`HUB75_WIDTH);
    localparam int ROW_W      = $clog2(`HUB75_HALF_HEIGHT);
    localparam int PLANE_W    = $clog2(`HUB75_PLANES);
    localparam int NUM_PIXELS = 2 * `HUB75_HALF_HEIGHT * `HUB75_WIDTH;
    localparam int ADDR_W     = $clog2(NUM_PIXELS);

    // one framebuffer word
    typedef struct packed {
        logic [`HUB75_PLANES-1:0] red;
        logic [`HUB75_PLANES-1:0] green;
        logic [`HUB75_PLANES-1:0] blue;
    } pixel_t;

    typedef logic [ADDR_W-1:0] fb_addr_t; // row * width + column

    typedef struct packed {
        logic [2:0]               rgb_enable;   // [2] red, [1] green, [0] blue
        logic [`HUB75_PLANES-1:0] plane_enable;
    } ctrl_t;

    localparam ctrl_t CTRL_RESET = '1; // everything on

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    // what the scan asks the fetch for
    typedef struct packed {
        logic [COL_W-1:0]   column;
        logic [ROW_W-1:0]   row;     // row within the half
        logic [PLANE_W-1:0] plane;
    } col_req_t;

    // panel pins
    typedef struct packed {
        rgb_t             rgb_top;
        rgb_t             rgb_bottom;
        logic [ROW_W-1:0] row;
        logic             clk_pixel;
        logic             latch;
        logic             oe_n;
    } hub75_t;

endpackage

/* src/hub75_top.sv */
// ------------------------------------------------------------------------
// top level of the HUB75 driver, host writes the framebuffer over APB
// and the scan drives the panel pins from it
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "hub75_defs.svh"

module hub75_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`HUB75_APB_AW-1:0]  paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output hub75_pkg::hub75_t         panel
);
    import hub75_pkg::*;

    logic     ram_a_en, ram_a_we;
    fb_addr_t ram_a_addr;
    pixel_t   ram_a_wdata, ram_a_rdata;
    logic     ram_b_en;
    fb_addr_t ram_b_addr;
    pixel_t   ram_b_rdata;
    ctrl_t    ctrl;
    logic     fetch_req, rsp_valid;
    col_req_t fetch_info;
    rgb_t     rgb_top, rgb_bottom;

    fb_apb_regs u_regs (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .ram_en(ram_a_en), .ram_we(ram_a_we), .ram_addr(ram_a_addr),
        .ram_wdata(ram_a_wdata), .ram_rdata(ram_a_rdata), .ctrl
    );

    framebuffer_ram u_ram (
        .clk,
        .a_en(ram_a_en), .a_we(ram_a_we), .a_addr(ram_a_addr),
        .a_wdata(ram_a_wdata), .a_rdata(ram_a_rdata),
        .b_en(ram_b_en), .b_addr(ram_b_addr), .b_rdata(ram_b_rdata)
    );

    framebuffer_fetch u_fetch (
        .clk, .arst_n, .req(fetch_req), .req_info(fetch_info), .ctrl,
        .ram_en(ram_b_en), .ram_addr(ram_b_addr), .ram_rdata(ram_b_rdata),
        .rsp_valid, .rgb_top, .rgb_bottom
    );

    matrix_scan u_scan (
        .clk, .arst_n, .req(fetch_req), .req_info(fetch_info),
        .rsp_valid, .rgb_top, .rgb_bottom, .panel
    );

endmodule

/* src/matrix_scan.sv */
// ------------------------------------------------------------------------
// scan FSM, per plane shifts a row column by column, latches it and
// enables the display for a time weighted by the plane
// ------------------------------------------------------------------------
`timescale 1ns/1ps
`include "hub75_defs.svh"

module matrix_scan (
    input  logic                 clk,
    input  logic                 arst_n,
    output logic                 req,
    output hub75_pkg::col_req_t  req_info,
    input  logic                 rsp_valid,
    input  hub75_pkg::rgb_t      rgb_top,
    input  hub75_pkg::rgb_t      rgb_bottom,
    output hub75_pkg::hub75_t    panel
);
    import hub75_pkg::*;

    localparam int OE_W = $clog2((`HUB75_OE_BASE << (`HUB75_PLANES - 1)) + 1);

    typedef enum logic [2:0] {
        S_FETCH,  // ask for the column
        S_WAIT,   // wait for the colour bits
        S_SETUP,  // data on the pins, clock still low
        S_PULSE,  // clk_pixel high
        S_LATCH,  // latch high
        S_SHOW    // oe_n low
    } state_t;

    state_t             state;
    logic [COL_W-1:0]   col_q;
    logic [ROW_W-1:0]   row_q;
    logic [PLANE_W-1:0] plane_q;
    logic [OE_W-1:0]    oe_cnt;

    assign req = (state == S_FETCH);

    always_comb begin
        req_info.column = col_q;
        req_info.row    = row_q;
        req_info.plane  = plane_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_FETCH;
            col_q   <= '0;
            row_q   <= '0;
            plane_q <= '0;
            oe_cnt  <= '0;
            panel   <= '{oe_n: 1'b1, default: '0};
        end else begin
            case (state)
                S_FETCH: state <= S_WAIT;
                S_WAIT: if (rsp_valid) begin
                    panel.rgb_top    <= rgb_top;
                    panel.rgb_bottom <= rgb_bottom;
                    state            <= S_SETUP;
                end
                S_SETUP: begin
                    panel.clk_pixel <= 1'b1;
                    state           <= S_PULSE;
                end
                S_PULSE: begin
                    panel.clk_pixel <= 1'b0;
                    if (col_q == COL_W'(`HUB75_WIDTH - 1)) begin
                        col_q       <= '0;
                        panel.latch <= 1'b1;
                        panel.row   <= row_q;
                        state       <= S_LATCH;
                    end else begin
                        col_q <= col_q + 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_LATCH: begin
                    panel.latch <= 1'b0;
                    panel.oe_n  <= 1'b0;
                    oe_cnt      <= OE_W'((`HUB75_OE_BASE << plane_q) - 1);
                    state       <= S_SHOW;
                end
                S_SHOW: if (oe_cnt == '0) begin
                    panel.oe_n <= 1'b1;
                    state      <= S_FETCH;
                    if (plane_q == PLANE_W'(`HUB75_PLANES - 1)) begin
                        plane_q <= '0;
                        row_q   <= (row_q == ROW_W'(`HUB75_HALF_HEIGHT - 1)) ? '0
                                   : row_q + 1'b1;
                    end else begin
                        plane_q <= plane_q + 1'b1;
                    end
                end else begin
                    oe_cnt <= oe_cnt - 1'b1;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

endmodule
